// ==== source/display_cfg_pkg.sv ====
package display_cfg_pkg;

    // Display geometry
    localparam int num_digits = 6;                      // Digits fitted on the board
    localparam int data_width = 20;                     // Wide enough for 999999

    // Serial frame towards the two 74HC595 chips
    localparam int seg_bits   = 8;                      // Seven segments plus point
    localparam int frame_bits = num_digits + seg_bits;  // Select bits go out first
    localparam int bit_div    = 4;                      // sys_clk cycles per serial bit

    // One-hot digit select, bit 0 drives the units digit.
    // All zero means no digit is lit.
    typedef logic [num_digits-1:0] sel_t;

endpackage

// ==== source/segment_pkg.sv ====
package segment_pkg;

    // Segment pattern, active low
    // Bit 7 is the decimal point, bits 6..0 are segments g..a
    typedef logic [7:0] seg_t;

    typedef logic [3:0] bcd_t;                          // One decimal digit

    localparam int   dp_bit    = 7;                     // Decimal point position in seg_t
    localparam seg_t seg_blank = 8'hff;                 // Every segment dark

    // Digit to segment lookup, decimal point left dark
    function automatic seg_t seg_pattern(bcd_t digit);
        seg_t pattern;
        case (digit)
            4'd0:    pattern = 8'hc0;
            4'd1:    pattern = 8'hf9;
            4'd2:    pattern = 8'ha4;
            4'd3:    pattern = 8'hb0;
            4'd4:    pattern = 8'h99;
            4'd5:    pattern = 8'h92;
            4'd6:    pattern = 8'h82;
            4'd7:    pattern = 8'hf8;
            4'd8:    pattern = 8'h80;
            4'd9:    pattern = 8'h90;
            default: pattern = seg_blank;               // Codes 10..15 show nothing
        endcase
        return pattern;
    endfunction

endpackage

// ==== source/bin_to_bcd.sv ====
`timescale 1ns/1ps

module bin_to_bcd #(
    parameter int NUM_DIGITS = 6,
    parameter int DATA_WIDTH = 20
) (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    input  logic [DATA_WIDTH-1:0]              data,
    output segment_pkg::bcd_t [NUM_DIGITS-1:0] digit_val,
    output logic [NUM_DIGITS-1:0]              blank
);

    localparam int cnt_width = $clog2(DATA_WIDTH + 1);
    localparam logic [DATA_WIDTH-1:0] max_value = DATA_WIDTH'(10 ** NUM_DIGITS - 1);

    logic [cnt_width-1:0]    step_cnt;                  // 0 loads, 1..DATA_WIDTH shift
    logic [DATA_WIDTH-1:0]   bin_sr;                    // Binary bits still to shift in
    logic [4*NUM_DIGITS-1:0] bcd_acc;
    logic [4*NUM_DIGITS-1:0] bcd_adj;
    logic [4*NUM_DIGITS-1:0] bcd_next;
    logic                    last_step;

    assign last_step = (step_cnt == cnt_width'(DATA_WIDTH));

    // One double-dabble step: add 3 to every digit above 4, then shift left
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (bcd_acc[4*i +: 4] >= 4'd5)
                bcd_adj[4*i +: 4] = bcd_acc[4*i +: 4] + 4'd3;
            else
                bcd_adj[4*i +: 4] = bcd_acc[4*i +: 4];
        end
        bcd_next = {bcd_adj[4*NUM_DIGITS-2:0], bin_sr[DATA_WIDTH-1]};
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            step_cnt  <= '0;
            digit_val <= '0;
        end else begin
            if (last_step) begin
                step_cnt  <= '0;                        // Next cycle samples data again
                digit_val <= bcd_next;                  // All digits update at once
            end else begin
                step_cnt  <= step_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (step_cnt == '0) begin
            bin_sr  <= (data > max_value) ? max_value : data;  // Saturate out-of-range input
            bcd_acc <= '0;
        end else begin
            bin_sr  <= {bin_sr[DATA_WIDTH-2:0], 1'b0};
            bcd_acc <= bcd_next;
        end
    end

    // Leading zeros go dark, the units digit always shows
    always_comb begin
        blank[NUM_DIGITS-1] = (digit_val[NUM_DIGITS-1] == 4'd0);
        for (int i = NUM_DIGITS - 2; i > 0; i--) begin
            blank[i] = blank[i+1] && (digit_val[i] == 4'd0);
        end
        blank[0] = 1'b0;
    end

    generate
        for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit_chk
            a_digit_range: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                last_step |=> (digit_val[i] <= 4'd9))
                else $error("bin_to_bcd: digit %0d holds %0d after conversion", i, digit_val[i]);
        end
    endgenerate

endmodule

// ==== source/digit_decoder.sv ====
`timescale 1ns/1ps

module digit_decoder (
    input  segment_pkg::bcd_t digit_val,
    input  logic              blank,
    input  logic              point,
    output segment_pkg::seg_t digit_seg
);

    segment_pkg::seg_t base_seg;                        // Pattern before the point is added

    // A blanked digit shows no segments at all
    always_comb begin
        if (blank)
            base_seg = segment_pkg::seg_blank;
        else
            base_seg = segment_pkg::seg_pattern(digit_val);
    end

    // The point is independent of blanking, so a dark digit can still carry it
    always_comb begin
        digit_seg = base_seg;
        if (point)
            digit_seg[segment_pkg::dp_bit] = 1'b0;      // Active low
    end

endmodule

// ==== source/digit_scanner.sv ====
`timescale 1ns/1ps

module digit_scanner #(
    parameter int NUM_DIGITS  = 6,
    parameter int SCAN_CYCLES = 50000
) (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    input  logic                               seg_en,
    input  segment_pkg::seg_t [NUM_DIGITS-1:0] digit_seg,
    output display_cfg_pkg::sel_t              sel,
    output segment_pkg::seg_t                  seg
);

    localparam int dwell_width = $clog2(SCAN_CYCLES + 1);
    localparam int idx_width   = $clog2(NUM_DIGITS);
    localparam logic [dwell_width-1:0] dwell_last = dwell_width'(SCAN_CYCLES - 1);
    localparam logic [idx_width-1:0]   idx_last   = idx_width'(NUM_DIGITS - 1);

    logic [dwell_width-1:0] dwell_cnt;                  // Clocks spent on the current digit
    logic [idx_width-1:0]   digit_idx;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            dwell_cnt <= '0;
            digit_idx <= '0;                            // Start on the units digit
        end else if (dwell_cnt == dwell_last) begin
            dwell_cnt <= '0;
            if (digit_idx == idx_last)
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Select and pattern change together
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            sel <= '0;
            seg <= segment_pkg::seg_blank;
        end else if (seg_en) begin
            sel <= display_cfg_pkg::sel_t'(1'b1) << digit_idx;
            seg <= digit_seg[digit_idx];
        end else begin
            sel <= '0;                                  // Display switched off
            seg <= segment_pkg::seg_blank;
        end
    end

    a_sel_enabled: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        seg_en |=> $onehot(sel))
        else $error("digit_scanner: select %b is not one-hot while enabled", sel);

endmodule

// ==== source/hc595_ctrl.sv ====
`timescale 1ns/1ps

module hc595_ctrl #(
    parameter int FRAME_BITS = 14
) (
    input  logic                  sys_clk,
    input  logic                  sys_rst_n,
    input  display_cfg_pkg::sel_t sel,
    input  segment_pkg::seg_t     seg,
    output logic                  shcp,
    output logic                  stcp,
    output logic                  ds,
    output logic                  oe
);

    localparam int ph_width  = $clog2(display_cfg_pkg::bit_div);
    localparam int bit_width = $clog2(FRAME_BITS);
    localparam logic [ph_width-1:0]  ph_last  = ph_width'(display_cfg_pkg::bit_div - 1);
    localparam logic [ph_width-1:0]  ph_shift = ph_width'(display_cfg_pkg::bit_div / 2);
    localparam logic [bit_width-1:0] bit_last = bit_width'(FRAME_BITS - 1);

    logic [ph_width-1:0]   phase_cnt;                   // Position inside one serial bit
    logic [bit_width-1:0]  bit_cnt;                     // Position inside the frame
    logic                  frame_start;
    segment_pkg::seg_t     seg_rev;
    logic [FRAME_BITS-1:0] new_word;
    logic [FRAME_BITS-1:0] word_reg;
    logic [FRAME_BITS-1:0] tx_word;

    // Segment bits leave in reverse order, point first after the select bits
    always_comb begin
        for (int k = 0; k < $bits(segment_pkg::seg_t); k++) begin
            seg_rev[k] = seg[$bits(segment_pkg::seg_t)-1-k];
        end
    end

    assign new_word    = {seg_rev, sel};
    assign frame_start = (bit_cnt == '0) && (phase_cnt == '0);
    assign tx_word     = frame_start ? new_word : word_reg;  // Bit 0 goes out as it is captured
    assign oe          = ~sys_rst_n;                         // Outputs dark during reset

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            phase_cnt <= '0;
            bit_cnt   <= '0;
        end else if (phase_cnt == ph_last) begin
            phase_cnt <= '0;
            bit_cnt   <= (bit_cnt == bit_last) ? '0 : bit_cnt + 1'b1;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (frame_start)
            word_reg <= new_word;                       // One consistent word per frame
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ds   <= 1'b0;
            shcp <= 1'b0;
            stcp <= 1'b0;
        end else begin
            if (phase_cnt == '0)
                ds <= tx_word[bit_cnt];
            if (phase_cnt == ph_shift)
                shcp <= 1'b1;                           // Shift edge mid-bit
            else if (phase_cnt == '0)
                shcp <= 1'b0;
            if (frame_start)
                stcp <= 1'b1;                           // Latches the previous frame
            else if (bit_cnt == bit_width'(2) && phase_cnt == '0)
                stcp <= 1'b0;
        end
    end

    // The shift clock stays low while ds settles after a change
    a_shcp_setup: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (phase_cnt != '0) && (phase_cnt <= ph_shift) |-> !shcp)
        else $error("hc595_ctrl: shcp high in phase %0d", phase_cnt);

endmodule

// ==== source/seg_display_top.sv ====
`timescale 1ns/1ps

module seg_display_top #(
    parameter int SCAN_CYCLES = 50000                   // Dwell per digit in sys_clk cycles
) (
    input  logic                                   sys_clk,
    input  logic                                   sys_rst_n,
    input  logic [display_cfg_pkg::data_width-1:0] data,
    input  logic [display_cfg_pkg::num_digits-1:0] point,
    input  logic                                   seg_en,
    output logic                                   ds,
    output logic                                   shcp,
    output logic                                   stcp,
    output logic                                   oe
);

    segment_pkg::bcd_t [display_cfg_pkg::num_digits-1:0] digit_val;
    logic              [display_cfg_pkg::num_digits-1:0] blank;
    segment_pkg::seg_t [display_cfg_pkg::num_digits-1:0] digit_seg;
    display_cfg_pkg::sel_t                               sel;
    segment_pkg::seg_t                                   seg;

    bin_to_bcd #(
        .NUM_DIGITS (display_cfg_pkg::num_digits),
        .DATA_WIDTH (display_cfg_pkg::data_width)
    ) bin_to_bcd_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .data      (data),
        .digit_val (digit_val),
        .blank     (blank)
    );

    generate
        for (genvar i = 0; i < display_cfg_pkg::num_digits; i++) begin : g_decoder
            digit_decoder digit_decoder_inst (
                .digit_val (digit_val[i]),
                .blank     (blank[i]),
                .point     (point[i]),
                .digit_seg (digit_seg[i])
            );
        end
    endgenerate

    digit_scanner #(
        .NUM_DIGITS  (display_cfg_pkg::num_digits),
        .SCAN_CYCLES (SCAN_CYCLES)
    ) digit_scanner_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .seg_en    (seg_en),
        .digit_seg (digit_seg),
        .sel       (sel),
        .seg       (seg)
    );

    hc595_ctrl #(
        .FRAME_BITS (display_cfg_pkg::frame_bits)
    ) hc595_ctrl_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .sel       (sel),
        .seg       (seg),
        .shcp      (shcp),
        .stcp      (stcp),
        .ds        (ds),
        .oe        (oe)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,                    // ns, gives a 40 ns clock
    parameter int RESET_CYCLES = 5
) (
    output logic sys_clk,
    output logic sys_rst_n
);

    initial begin
        sys_clk = 1'b0;
        forever #(HALF_PERIOD) sys_clk = ~sys_clk;
    end

    initial begin
        sys_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        #2 sys_rst_n = 1'b1;                            // Released just after an edge
    end

endmodule

// ==== verification/hc595_model.sv ====
`timescale 1ns/1ps

module hc595_model (
    input  logic                  ds,
    input  logic                  shcp,
    input  logic                  stcp,
    output display_cfg_pkg::sel_t sel,
    output segment_pkg::seg_t     seg,
    output int                    frame_cnt
);

    localparam int nd = display_cfg_pkg::num_digits;
    localparam int fb = display_cfg_pkg::frame_bits;

    logic [fb-1:0] shift_reg;                           // First bit sent ends up at the top
    int            shift_cnt;                           // Shifts since the last latch

    initial begin
        shift_reg = '0;
        shift_cnt = 0;
        sel       = '0;
        seg       = segment_pkg::seg_blank;
        frame_cnt = 0;
    end

    always @(posedge shcp) begin
        shift_reg = {shift_reg[fb-2:0], ds};
        shift_cnt = shift_cnt + 1;
    end

    // Word bit k sits at shift_reg[fb-1-k] once the frame is complete
    always @(posedge stcp) begin
        for (int j = 0; j < nd; j++)
            sel[j] = shift_reg[fb-1-j];
        for (int m = 0; m < 8; m++)
            seg[7-m] = shift_reg[fb-1-(nd+m)];          // Point first and g down to a
        if (shift_cnt == fb)
            frame_cnt = frame_cnt + 1;                  // Only whole frames count
        shift_cnt = 0;
    end

endmodule

// ==== verification/seg_display_tb.sv ====
`timescale 1ns/1ps

module seg_display_tb;

    localparam int nd            = display_cfg_pkg::num_digits;
    localparam int max_shown     = 10 ** nd - 1;
    localparam int frame_clocks  = display_cfg_pkg::frame_bits * display_cfg_pkg::bit_div;
    localparam int frame_timeout = 3 * frame_clocks;
    localparam int convert_wait  = 2 * (display_cfg_pkg::data_width + 1) + 2;
    localparam int scan_cycles   = 112;
    localparam int frames_per_digit = scan_cycles / frame_clocks;

    logic                                   sys_clk;
    logic                                   sys_rst_n;
    logic [display_cfg_pkg::data_width-1:0] data;
    display_cfg_pkg::sel_t                  point;
    logic                                   seg_en;
    logic                                   ds;
    logic                                   shcp;
    logic                                   stcp;
    logic                                   oe;
    display_cfg_pkg::sel_t                  model_sel;
    segment_pkg::seg_t                      model_seg;
    int                                     frame_cnt;

    int     check_count;
    int     error_count;
    int     timeout_count;
    integer seed;

    tb_clock_gen tb_clock_gen_inst (.sys_clk(sys_clk), .sys_rst_n(sys_rst_n));

    seg_display_top #(
        .SCAN_CYCLES (scan_cycles)                      // Two serial frames per digit
    ) seg_display_top_inst (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .data      (data),
        .point     (point),
        .seg_en    (seg_en),
        .ds        (ds),
        .shcp      (shcp),
        .stcp      (stcp),
        .oe        (oe)
    );

    hc595_model hc595_model_inst (
        .ds        (ds),
        .shcp      (shcp),
        .stcp      (stcp),
        .sel       (model_sel),
        .seg       (model_seg),
        .frame_cnt (frame_cnt)
    );

    // Reference digit pattern from plain integer arithmetic
    function automatic segment_pkg::seg_t expected_seg(int value, display_cfg_pkg::sel_t pmask,
                                                       int idx);
        int                shown;
        int                upper;
        segment_pkg::seg_t pattern;
        shown = (value > max_shown) ? max_shown : value;
        upper = shown / (10 ** idx);
        if (idx != 0 && upper == 0)
            pattern = segment_pkg::seg_blank;           // Leading zero
        else
            pattern = segment_pkg::seg_pattern(segment_pkg::bcd_t'(upper % 10));
        if (pmask[idx])
            pattern[7] = 1'b0;
        return pattern;
    endfunction

    function automatic int sel_index(display_cfg_pkg::sel_t s);
        int idx;
        idx = -1;
        for (int i = nd - 1; i >= 0; i--)
            if (s[i])
                idx = i;                                // Lowest lit digit wins
        return idx;
    endfunction

    task automatic check_sel(display_cfg_pkg::sel_t actual, display_cfg_pkg::sel_t expected,
                             string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s, select %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_seg(segment_pkg::seg_t actual, segment_pkg::seg_t expected,
                             string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s, segments %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_bit(logic actual, logic expected, string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t: %s, got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (!sys_rst_n && waited < 20) begin
            @(posedge sys_clk);
            waited++;
        end
        if (!sys_rst_n) begin
            $display("Timeout at %0t: reset was never released", $time);
            timeout_count++;
        end
    endtask

    // Returns one ns after the edge on which the model latched a whole frame
    task automatic wait_frame();
        int start_cnt;
        int waited;
        start_cnt = frame_cnt;
        waited    = 0;
        while (frame_cnt == start_cnt && waited < frame_timeout) begin
            @(posedge sys_clk);
            #1;
            waited++;
        end
        if (frame_cnt == start_cnt) begin
            $display("Timeout at %0t: the shift register chain latched no frame", $time);
            timeout_count++;
        end
    endtask

    // Two conversions and then drop the frame that may hold older digits
    task automatic apply_input(int value, display_cfg_pkg::sel_t pmask, logic enable);
        @(posedge sys_clk);
        #2;
        data   = value[display_cfg_pkg::data_width-1:0];
        point  = pmask;
        seg_en = enable;
        repeat (convert_wait) @(posedge sys_clk);
        #1;
        wait_frame();
    endtask

    task automatic check_scan(int value, display_cfg_pkg::sel_t pmask, int frames, string what);
        display_cfg_pkg::sel_t prev;
        display_cfg_pkg::sel_t expected;
        display_cfg_pkg::sel_t seen;
        int                    idx;
        int                    run;
        logic                  first_digit;
        prev        = '0;
        seen        = '0;
        run         = 0;
        first_digit = 1'b1;
        for (int n = 0; n < frames; n++) begin
            wait_frame();
            if (prev == '0) begin
                idx      = sel_index(model_sel);
                expected = (idx < 0) ? display_cfg_pkg::sel_t'(1) :
                                       display_cfg_pkg::sel_t'(1) << idx;
                run      = 1;
            end else if (run < frames_per_digit && (!first_digit || model_sel == prev)) begin
                expected = prev;                        // Dwell continues on the same digit
                run      = run + 1;
            end else begin
                expected    = {prev[nd-2:0], prev[nd-1]};  // Next digit wraps to digit 0
                run         = 1;
                first_digit = 1'b0;
            end
            check_sel(model_sel, expected, what);
            check_seg(model_seg, expected_seg(value, pmask, sel_index(expected)), what);
            seen |= expected;
            prev  = expected;
        end
        if (frames >= 2 * nd)
            check_sel(seen, '1, {what, ", digits visited"});
    endtask

    task automatic reset_and_zero();
        int skipped;
        check_bit(oe, 1'b1, "oe during reset");
        wait_reset_release();
        @(posedge sys_clk);
        #1;
        check_bit(oe, 1'b0, "oe after reset");
        skipped = 0;
        wait_frame();
        while (model_sel == '0 && skipped < 3 && timeout_count == 0) begin
            check_seg(model_seg, segment_pkg::seg_blank, "idle frame after reset");
            skipped++;
            wait_frame();
        end
        check_sel(model_sel, display_cfg_pkg::sel_t'(1), "first digit after reset");
        check_seg(model_seg, expected_seg(0, '0, 0), "value 0 on digit 0");
        check_scan(0, '0, 2 * nd, "value 0");
    endtask

    task automatic leading_zero_blanking();
        apply_input(7005, '0, 1'b1);
        check_scan(7005, '0, 2 * nd, "value 7005");
        apply_input(7005, 6'b100000, 1'b1);
        check_scan(7005, 6'b100000, 2 * nd, "value 7005, point on blank digit 5");
    endtask

    task automatic random_values_with_points();
        int                    value;
        display_cfg_pkg::sel_t pmask;
        for (int n = 0; n < 20; n++) begin
            value = $unsigned($random(seed)) % (max_shown + 1);
            pmask = display_cfg_pkg::sel_t'($random(seed));
            apply_input(value, pmask, 1'b1);
            check_scan(value, pmask, 2 * nd, $sformatf("random value %0d", value));
        end
    endtask

    task automatic display_disable();
        apply_input(123456, 6'b000101, 1'b0);
        for (int n = 0; n < 4; n++) begin
            wait_frame();
            check_sel(model_sel, '0, "display disabled");
            check_seg(model_seg, segment_pkg::seg_blank, "display disabled");
        end
        apply_input(123456, 6'b000101, 1'b1);
        check_scan(123456, 6'b000101, 2 * nd, "display enabled again");
    endtask

    initial begin
        seed          = 91559;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        data          = '0;
        point         = '0;
        seg_en        = 1'b1;
        #1;
        reset_and_zero();
        if (timeout_count == 0) begin
            apply_input(123456, '0, 1'b1);
            check_scan(123456, '0, 2 * nd, "value 123456");
        end
        if (timeout_count == 0)
            leading_zero_blanking();
        if (timeout_count == 0)
            random_values_with_points();
        if (timeout_count == 0)
            display_disable();
        if (timeout_count == 0) begin
            apply_input(20'hfffff, '0, 1'b1);           // Above range so it shows 999999
            check_scan(20'hfffff, '0, 2 * nd, "saturated input");
        end
        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== seg_display.f ====
source/display_cfg_pkg.sv
source/segment_pkg.sv
source/bin_to_bcd.sv
source/digit_decoder.sv
source/digit_scanner.sv
source/hc595_ctrl.sv
source/seg_display_top.sv
verification/tb_clock_gen.sv
verification/hc595_model.sv
verification/seg_display_tb.sv
